/* common/id_remap_pkg.sv */
// Shared widths and channel payloads; ID widths are not defined here because they are module parameters.
package id_remap_pkg;

  // Address width of the AR and AW channels.
  localparam int unsigned ADDR_W = 32;
  // Read data width of the R channel.
  localparam int unsigned DATA_W = 32;
  // Width of the AXI burst length field.
  localparam int unsigned LEN_W = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [LEN_W-1:0]  len_t;

  // AXI response code, OKAY, EXOKAY, SLVERR or DECERR.
  typedef logic [1:0] resp_t;

  // Request payload shared by AR and AW.
  // The ID travels on its own port because its width differs between the two sides.
  typedef struct packed {
    addr_t addr;
    len_t  len;
  } ax_chan_t;

  // Payload of one read beat.
  typedef struct packed {
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

  // States of the request issue FSM.
  // The hold states keep a master request valid after the slave side was already pushed.
  typedef enum logic [1:0] {
    ST_READY,
    ST_HOLD_AR,
    ST_HOLD_AW,
    ST_HOLD_AX
  } issue_state_e;

endpackage

/* id_remap_table/id_remap_table.sv */
// Remap table for one direction; pushes must follow the admit rules of the issue FSM, pops need a live entry.
`timescale 1ns/1ps

module id_remap_table #(
  parameter int unsigned SLV_ID_W        = 6,
  parameter int unsigned MAX_UNIQ_IDS    = 4,
  parameter int unsigned MAX_TXNS_PER_ID = 2,
  localparam int unsigned OUP_ID_W = (MAX_UNIQ_IDS > 1) ? $clog2(MAX_UNIQ_IDS) : 1
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                push_i,
  input  logic [OUP_ID_W-1:0] push_oup_id_i,
  input  logic [SLV_ID_W-1:0] lookup_inp_id_i,
  input  logic                pop_i,
  input  logic [OUP_ID_W-1:0] pop_oup_id_i,
  output logic                full_o,
  output logic [OUP_ID_W-1:0] free_oup_id_o,
  output logic                hit_o,
  output logic [OUP_ID_W-1:0] hit_oup_id_o,
  output logic                hit_full_o,
  output logic [SLV_ID_W-1:0] pop_inp_id_o
);

  // The counter must be able to hold the limit itself.
  localparam int unsigned CNT_W = $clog2(MAX_TXNS_PER_ID + 1);

  typedef logic [SLV_ID_W-1:0] slv_id_t;
  typedef logic [OUP_ID_W-1:0] oup_id_t;
  typedef logic [CNT_W-1:0]    cnt_t;

  // The table is indexed by output ID.
  // Each entry holds the input ID it serves and the number of bursts in flight.
  slv_id_t inp_id_q [MAX_UNIQ_IDS];
  cnt_t    cnt_q    [MAX_UNIQ_IDS];
  cnt_t    cnt_d    [MAX_UNIQ_IDS];

  logic [MAX_UNIQ_IDS-1:0] free;
  logic [MAX_UNIQ_IDS-1:0] match;

  // An entry is free when its counter is zero.
  // A live entry matches when it stores the ID on the slave request channel.
  always_comb begin
    for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
      free[i]  = (cnt_q[i] == '0);
      match[i] = !free[i] && (inp_id_q[i] == lookup_inp_id_i);
    end
  end

  // Both searches walk down so that the lowest index wins.
  always_comb begin
    free_oup_id_o = '0;
    hit_oup_id_o  = '0;
    for (int i = MAX_UNIQ_IDS - 1; i >= 0; i--) begin
      if (free[i]) begin
        free_oup_id_o = oup_id_t'(i);
      end
      if (match[i]) begin
        hit_oup_id_o = oup_id_t'(i);
      end
    end
  end

  assign full_o     = ~|free;
  assign hit_o      = |match;
  assign hit_full_o = (cnt_q[hit_oup_id_o] == cnt_t'(MAX_TXNS_PER_ID));

  // The popped entry still holds its input ID in this cycle, so the response gets it directly.
  assign pop_inp_id_o = inp_id_q[pop_oup_id_i];

  // Push and pop may hit the same entry, and then the count is unchanged.
  always_comb begin
    for (int i = 0; i < MAX_UNIQ_IDS; i++) begin
      cnt_d[i] = cnt_q[i];
      if (push_i && (push_oup_id_i == oup_id_t'(i))) begin
        cnt_d[i] = cnt_d[i] + cnt_t'(1);
      end
      if (pop_i && (pop_oup_id_i == oup_id_t'(i))) begin
        cnt_d[i] = cnt_d[i] - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '{default: '0};
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // The stored input ID only matters while the counter is nonzero.
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      inp_id_q[push_oup_id_i] <= lookup_inp_id_i;
    end
  end

  // The issue FSM may only push to a free entry, or to the entry of the same ID below the limit.
  a_push_legal: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push_i |-> (cnt_q[push_oup_id_i] == '0) ||
               ((inp_id_q[push_oup_id_i] == lookup_inp_id_i) &&
                (cnt_q[push_oup_id_i] < cnt_t'(MAX_TXNS_PER_ID))));

  // A master response must belong to a burst that is still in flight.
  a_pop_live: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> cnt_q[pop_oup_id_i] != '0);

  // Two live entries never serve the same input ID.
  a_match_unique: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(match));

endmodule

/* hdl/id_remap_issue.sv */
// Issue FSM for AR and AW; a request in a hold state blocks new requests on both channels until it is taken.
`timescale 1ns/1ps

module id_remap_issue import id_remap_pkg::*; #(
  parameter int unsigned MAX_UNIQ_IDS = 4,
  localparam int unsigned OUP_ID_W = (MAX_UNIQ_IDS > 1) ? $clog2(MAX_UNIQ_IDS) : 1
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                slv_ar_valid_i,
  input  logic                slv_aw_valid_i,
  input  logic                mst_ar_ready_i,
  input  logic                mst_aw_ready_i,
  input  logic                rd_full_i,
  input  logic [OUP_ID_W-1:0] rd_free_oup_id_i,
  input  logic                rd_hit_i,
  input  logic [OUP_ID_W-1:0] rd_hit_oup_id_i,
  input  logic                rd_hit_full_i,
  input  logic                wr_full_i,
  input  logic [OUP_ID_W-1:0] wr_free_oup_id_i,
  input  logic                wr_hit_i,
  input  logic [OUP_ID_W-1:0] wr_hit_oup_id_i,
  input  logic                wr_hit_full_i,
  output logic                slv_ar_ready_o,
  output logic                slv_aw_ready_o,
  output logic                mst_ar_valid_o,
  output logic                mst_aw_valid_o,
  output logic [OUP_ID_W-1:0] mst_ar_id_o,
  output logic [OUP_ID_W-1:0] mst_aw_id_o,
  output logic                rd_push_o,
  output logic                wr_push_o
);

  typedef logic [OUP_ID_W-1:0] oup_id_t;

  issue_state_e state_q, state_d;
  oup_id_t      ar_id_q, aw_id_q;
  oup_id_t      rd_sel_id, wr_sel_id;
  logic         rd_admit, wr_admit;
  logic         ar_fwd, aw_fwd;
  logic         ar_stall, aw_stall;

  // A known ID is admitted below its limit, and a new ID needs a free entry.
  assign rd_admit = rd_hit_i ? !rd_hit_full_i : !rd_full_i;
  assign wr_admit = wr_hit_i ? !wr_hit_full_i : !wr_full_i;

  // A known ID keeps its output ID so that the master returns its bursts in order.
  assign rd_sel_id = rd_hit_i ? rd_hit_oup_id_i : rd_free_oup_id_i;
  assign wr_sel_id = wr_hit_i ? wr_hit_oup_id_i : wr_free_oup_id_i;

  // These only take effect in ST_READY.
  assign ar_fwd   = slv_ar_valid_i && rd_admit;
  assign aw_fwd   = slv_aw_valid_i && wr_admit;
  assign ar_stall = ar_fwd && !mst_ar_ready_i;
  assign aw_stall = aw_fwd && !mst_aw_ready_i;

  always_comb begin
    state_d        = state_q;
    mst_ar_valid_o = 1'b0;
    mst_aw_valid_o = 1'b0;
    slv_ar_ready_o = 1'b0;
    slv_aw_ready_o = 1'b0;
    rd_push_o      = 1'b0;
    wr_push_o      = 1'b0;
    mst_ar_id_o    = ar_id_q;
    mst_aw_id_o    = aw_id_q;
    unique case (state_q)
      ST_READY: begin
        // The table is pushed in the first cycle, whether or not the master takes the request.
        mst_ar_id_o    = rd_sel_id;
        mst_aw_id_o    = wr_sel_id;
        mst_ar_valid_o = ar_fwd;
        mst_aw_valid_o = aw_fwd;
        rd_push_o      = ar_fwd;
        wr_push_o      = aw_fwd;
        slv_ar_ready_o = ar_fwd && mst_ar_ready_i;
        slv_aw_ready_o = aw_fwd && mst_aw_ready_i;
        if (ar_stall && aw_stall) begin
          state_d = ST_HOLD_AX;
        end else if (ar_stall) begin
          state_d = ST_HOLD_AR;
        end else if (aw_stall) begin
          state_d = ST_HOLD_AW;
        end
      end
      ST_HOLD_AR: begin
        mst_ar_valid_o = 1'b1;
        slv_ar_ready_o = mst_ar_ready_i;
        if (mst_ar_ready_i) begin
          state_d = ST_READY;
        end
      end
      ST_HOLD_AW: begin
        mst_aw_valid_o = 1'b1;
        slv_aw_ready_o = mst_aw_ready_i;
        if (mst_aw_ready_i) begin
          state_d = ST_READY;
        end
      end
      ST_HOLD_AX: begin
        // Whichever side completes first leaves the other one held.
        mst_ar_valid_o = 1'b1;
        mst_aw_valid_o = 1'b1;
        slv_ar_ready_o = mst_ar_ready_i;
        slv_aw_ready_o = mst_aw_ready_i;
        unique case ({mst_ar_ready_i, mst_aw_ready_i})
          2'b11:   state_d = ST_READY;
          2'b10:   state_d = ST_HOLD_AW;
          2'b01:   state_d = ST_HOLD_AR;
          default: state_d = ST_HOLD_AX;
        endcase
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_READY;
    end else begin
      state_q <= state_d;
    end
  end

  // The held output IDs are captured only on the cycle a stall begins.
  always_ff @(posedge clk_i) begin
    if ((state_q == ST_READY) && ar_stall) begin
      ar_id_q <= rd_sel_id;
    end
    if ((state_q == ST_READY) && aw_stall) begin
      aw_id_q <= wr_sel_id;
    end
  end

  // A request the master has not taken stays valid with the same ID.
  a_ar_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o && $stable(mst_ar_id_o));
  a_aw_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o && $stable(mst_aw_id_o));

endmodule

/* hdl/id_remap_top.sv */
// ID remapper top; W passes outside this block, and master IDs are exactly the table index width.
`timescale 1ns/1ps

module id_remap_top import id_remap_pkg::*; #(
  parameter int unsigned SLV_ID_W        = 6,
  parameter int unsigned MAX_UNIQ_IDS    = 4,
  parameter int unsigned MAX_TXNS_PER_ID = 2,
  localparam int unsigned OUP_ID_W = (MAX_UNIQ_IDS > 1) ? $clog2(MAX_UNIQ_IDS) : 1
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Slave side with wide input IDs.
  input  ax_chan_t            slv_ar_i,
  input  logic [SLV_ID_W-1:0] slv_ar_id_i,
  input  logic                slv_ar_valid_i,
  output logic                slv_ar_ready_o,
  input  ax_chan_t            slv_aw_i,
  input  logic [SLV_ID_W-1:0] slv_aw_id_i,
  input  logic                slv_aw_valid_i,
  output logic                slv_aw_ready_o,
  output resp_t               slv_b_o,
  output logic [SLV_ID_W-1:0] slv_b_id_o,
  output logic                slv_b_valid_o,
  input  logic                slv_b_ready_i,
  output r_chan_t             slv_r_o,
  output logic [SLV_ID_W-1:0] slv_r_id_o,
  output logic                slv_r_valid_o,
  input  logic                slv_r_ready_i,
  // Master side with dense output IDs.
  output ax_chan_t            mst_ar_o,
  output logic [OUP_ID_W-1:0] mst_ar_id_o,
  output logic                mst_ar_valid_o,
  input  logic                mst_ar_ready_i,
  output ax_chan_t            mst_aw_o,
  output logic [OUP_ID_W-1:0] mst_aw_id_o,
  output logic                mst_aw_valid_o,
  input  logic                mst_aw_ready_i,
  input  resp_t               mst_b_i,
  input  logic [OUP_ID_W-1:0] mst_b_id_i,
  input  logic                mst_b_valid_i,
  output logic                mst_b_ready_o,
  input  r_chan_t             mst_r_i,
  input  logic [OUP_ID_W-1:0] mst_r_id_i,
  input  logic                mst_r_valid_i,
  output logic                mst_r_ready_o
);

  typedef logic [OUP_ID_W-1:0] oup_id_t;

  logic    rd_full, rd_hit, rd_hit_full, rd_push, rd_pop;
  logic    wr_full, wr_hit, wr_hit_full, wr_push, wr_pop;
  oup_id_t rd_free_oup_id, rd_hit_oup_id;
  oup_id_t wr_free_oup_id, wr_hit_oup_id;

  // Request payloads are not touched, only their IDs are replaced.
  assign mst_ar_o = slv_ar_i;
  assign mst_aw_o = slv_aw_i;

  // Responses pass straight back, and the tables restore their IDs.
  assign slv_b_o       = mst_b_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;
  assign slv_r_o       = mst_r_i;
  assign slv_r_valid_o = mst_r_valid_i;
  assign mst_r_ready_o = slv_r_ready_i;

  // A write burst ends with its B response, and a read burst ends with its last R beat.
  assign wr_pop = mst_b_valid_i && slv_b_ready_i;
  assign rd_pop = mst_r_valid_i && slv_r_ready_i && mst_r_i.last;

  id_remap_table #(
    .SLV_ID_W        (SLV_ID_W),
    .MAX_UNIQ_IDS    (MAX_UNIQ_IDS),
    .MAX_TXNS_PER_ID (MAX_TXNS_PER_ID)
  ) u_wr_table (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .push_i          (wr_push),
    .push_oup_id_i   (mst_aw_id_o),
    .lookup_inp_id_i (slv_aw_id_i),
    .pop_i           (wr_pop),
    .pop_oup_id_i    (mst_b_id_i),
    .full_o          (wr_full),
    .free_oup_id_o   (wr_free_oup_id),
    .hit_o           (wr_hit),
    .hit_oup_id_o    (wr_hit_oup_id),
    .hit_full_o      (wr_hit_full),
    .pop_inp_id_o    (slv_b_id_o)
  );

  id_remap_table #(
    .SLV_ID_W        (SLV_ID_W),
    .MAX_UNIQ_IDS    (MAX_UNIQ_IDS),
    .MAX_TXNS_PER_ID (MAX_TXNS_PER_ID)
  ) u_rd_table (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .push_i          (rd_push),
    .push_oup_id_i   (mst_ar_id_o),
    .lookup_inp_id_i (slv_ar_id_i),
    .pop_i           (rd_pop),
    .pop_oup_id_i    (mst_r_id_i),
    .full_o          (rd_full),
    .free_oup_id_o   (rd_free_oup_id),
    .hit_o           (rd_hit),
    .hit_oup_id_o    (rd_hit_oup_id),
    .hit_full_o      (rd_hit_full),
    .pop_inp_id_o    (slv_r_id_o)
  );

  // The push ID is the master ID, which the FSM drives in the push cycle.
  id_remap_issue #(
    .MAX_UNIQ_IDS (MAX_UNIQ_IDS)
  ) u_issue (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .slv_ar_valid_i   (slv_ar_valid_i),
    .slv_aw_valid_i   (slv_aw_valid_i),
    .mst_ar_ready_i   (mst_ar_ready_i),
    .mst_aw_ready_i   (mst_aw_ready_i),
    .rd_full_i        (rd_full),
    .rd_free_oup_id_i (rd_free_oup_id),
    .rd_hit_i         (rd_hit),
    .rd_hit_oup_id_i  (rd_hit_oup_id),
    .rd_hit_full_i    (rd_hit_full),
    .wr_full_i        (wr_full),
    .wr_free_oup_id_i (wr_free_oup_id),
    .wr_hit_i         (wr_hit),
    .wr_hit_oup_id_i  (wr_hit_oup_id),
    .wr_hit_full_i    (wr_hit_full),
    .slv_ar_ready_o   (slv_ar_ready_o),
    .slv_aw_ready_o   (slv_aw_ready_o),
    .mst_ar_valid_o   (mst_ar_valid_o),
    .mst_aw_valid_o   (mst_aw_valid_o),
    .mst_ar_id_o      (mst_ar_id_o),
    .mst_aw_id_o      (mst_aw_id_o),
    .rd_push_o        (rd_push),
    .wr_push_o        (wr_push)
  );

  // A waiting slave request stays valid and unchanged, as the master sees its payload directly.
  a_slv_ar_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    slv_ar_valid_i && !slv_ar_ready_o |=>
      slv_ar_valid_i && $stable(slv_ar_id_i) && $stable(slv_ar_i));
  a_slv_aw_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    slv_aw_valid_i && !slv_aw_ready_o |=>
      slv_aw_valid_i && $stable(slv_aw_id_i) && $stable(slv_aw_i));

endmodule

/* tb/mst_responder.sv */
// Master model with in-order responses per direction; holds at most 16 bursts per direction.
`timescale 1ns/1ps

module mst_responder import id_remap_pkg::*; #(
  parameter int unsigned OUP_ID_W = 2
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                hold_i,
  input  logic                b_rel_i,
  input  logic                r_rel_i,
  input  ax_chan_t            ar_i,
  input  logic [OUP_ID_W-1:0] ar_id_i,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  input  logic [OUP_ID_W-1:0] aw_id_i,
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  output resp_t               b_o,
  output logic [OUP_ID_W-1:0] b_id_o,
  output logic                b_valid_o,
  input  logic                b_ready_i,
  output r_chan_t             r_o,
  output logic [OUP_ID_W-1:0] r_id_o,
  output logic                r_valid_o,
  input  logic                r_ready_i
);

  // Accepted bursts wait in two small ring buffers, oldest first.
  logic [OUP_ID_W-1:0] rd_id [16];
  addr_t               rd_addr [16];
  len_t                rd_len [16];
  logic [OUP_ID_W-1:0] wr_id [16];
  logic [3:0]          rd_head, rd_tail, wr_head, wr_tail;
  len_t                beat;

  assign ar_ready_o = !hold_i;
  assign aw_ready_o = !hold_i;

  // Read data is the burst address plus the beat number.
  // Every response carries SLVERR, a code the remapper must pass back unchanged.
  assign r_valid_o = r_rel_i && (rd_head != rd_tail);
  assign r_id_o    = rd_id[rd_head];
  assign r_o.data  = rd_addr[rd_head] + data_t'(beat);
  assign r_o.resp  = 2'b10;
  assign r_o.last  = (beat == rd_len[rd_head]);
  assign b_valid_o = b_rel_i && (wr_head != wr_tail);
  assign b_id_o    = wr_id[wr_head];
  assign b_o       = 2'b10;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_head <= '0;
      rd_tail <= '0;
      wr_head <= '0;
      wr_tail <= '0;
      beat    <= '0;
    end else begin
      if (ar_valid_i && ar_ready_o) begin
        rd_id[rd_tail]   <= ar_id_i;
        rd_addr[rd_tail] <= ar_i.addr;
        rd_len[rd_tail]  <= ar_i.len;
        rd_tail          <= rd_tail + 4'd1;
      end
      if (aw_valid_i && aw_ready_o) begin
        wr_id[wr_tail] <= aw_id_i;
        wr_tail        <= wr_tail + 4'd1;
      end
      if (r_valid_o && r_ready_i) begin
        if (r_o.last) begin
          rd_head <= rd_head + 4'd1;
          beat    <= '0;
        end else begin
          beat <= beat + len_t'(1);
        end
      end
      if (b_valid_o && b_ready_i) begin
        wr_head <= wr_head + 4'd1;
      end
    end
  end

endmodule

/* tb/id_remap_tb.sv */
// Runs with 6-bit input IDs, 4 output IDs and 2 bursts per ID; master responses come back in order.
`timescale 1ns/1ps

module id_remap_tb import id_remap_pkg::*;;

  // One step of the table: direction, input ID, burst length, master stall cycles,
  // responses released during a slave stall, whether it stalls, and the expected output ID.
  typedef struct packed {
    logic       wr;
    logic [5:0] id;
    len_t       len;
    logic [3:0] hold;
    logic [3:0] n_rel;
    logic       stall;
    logic [1:0] oup;
  } row_t;

  logic clk_i, arst_n_i;
  logic dir_wr, req_valid, hold, b_rel, r_rel, timed_out;
  logic [5:0] req_id;
  ax_chan_t req_ax, mst_ar, mst_aw;
  logic [1:0] mst_ar_id, mst_aw_id, mst_b_id, mst_r_id;
  logic slv_ar_ready, slv_aw_ready, mst_ar_valid, mst_aw_valid, mst_ar_ready, mst_aw_ready;
  resp_t slv_b, mst_b;
  r_chan_t slv_r, mst_r;
  logic [5:0] slv_b_id, slv_r_id;
  logic slv_b_valid, slv_r_valid, mst_b_valid, mst_r_valid, mst_b_ready, mst_r_ready;
  logic [31:0] lfsr;
  int errors;
  len_t tb_beat;
  row_t rows [12];
  logic [5:0] rd_ref_id [$];
  addr_t rd_ref_addr [$];
  len_t rd_ref_len [$];
  logic [5:0] wr_ref_id [$];

  // The request signals of the selected direction.
  wire        sel_slv_ready = dir_wr ? slv_aw_ready : slv_ar_ready;
  wire len_t  sel_mst_len = dir_wr ? mst_aw.len : mst_ar.len;
  wire        sel_mst_valid = dir_wr ? mst_aw_valid : mst_ar_valid;
  wire [1:0]  sel_mst_id = dir_wr ? mst_aw_id : mst_ar_id;
  wire addr_t sel_mst_addr = dir_wr ? mst_aw.addr : mst_ar.addr;

  id_remap_top #(.SLV_ID_W(6), .MAX_UNIQ_IDS(4), .MAX_TXNS_PER_ID(2)) DUT (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .slv_ar_i(req_ax), .slv_ar_id_i(req_id), .slv_ar_valid_i(req_valid && !dir_wr),
    .slv_ar_ready_o(slv_ar_ready),
    .slv_aw_i(req_ax), .slv_aw_id_i(req_id), .slv_aw_valid_i(req_valid && dir_wr),
    .slv_aw_ready_o(slv_aw_ready),
    .slv_b_o(slv_b), .slv_b_id_o(slv_b_id), .slv_b_valid_o(slv_b_valid), .slv_b_ready_i(1'b1),
    .slv_r_o(slv_r), .slv_r_id_o(slv_r_id), .slv_r_valid_o(slv_r_valid), .slv_r_ready_i(1'b1),
    .mst_ar_o(mst_ar), .mst_ar_id_o(mst_ar_id), .mst_ar_valid_o(mst_ar_valid),
    .mst_ar_ready_i(mst_ar_ready),
    .mst_aw_o(mst_aw), .mst_aw_id_o(mst_aw_id), .mst_aw_valid_o(mst_aw_valid),
    .mst_aw_ready_i(mst_aw_ready),
    .mst_b_i(mst_b), .mst_b_id_i(mst_b_id), .mst_b_valid_i(mst_b_valid),
    .mst_b_ready_o(mst_b_ready),
    .mst_r_i(mst_r), .mst_r_id_i(mst_r_id), .mst_r_valid_i(mst_r_valid),
    .mst_r_ready_o(mst_r_ready)
  );

  mst_responder #(.OUP_ID_W(2)) u_mst (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .hold_i(hold), .b_rel_i(b_rel), .r_rel_i(r_rel),
    .ar_i(mst_ar), .ar_id_i(mst_ar_id), .ar_valid_i(mst_ar_valid), .ar_ready_o(mst_ar_ready),
    .aw_id_i(mst_aw_id), .aw_valid_i(mst_aw_valid), .aw_ready_o(mst_aw_ready),
    .b_o(mst_b), .b_id_o(mst_b_id), .b_valid_o(mst_b_valid), .b_ready_i(mst_b_ready),
    .r_o(mst_r), .r_id_o(mst_r_id), .r_valid_o(mst_r_valid), .r_ready_i(mst_r_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Taps 32, 22, 2 and 1; one step per address bit.
  task automatic draw_addr(output addr_t a);
    for (int i = 0; i < 32; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      a[i] = lfsr[0];
    end
  endtask

  // Lets the master return one response and checks it against the oldest burst.
  task automatic release_one(input logic wr);
    logic seen;
    seen = 1'b0;
    @(posedge clk_i);
    #1;
    b_rel = wr;
    r_rel = !wr;
    for (int t = 0; t < 20 && !seen; t++) begin
      @(negedge clk_i);
      seen = wr ? slv_b_valid : slv_r_valid;
    end
    if (!seen) begin
      $display("timeout at %0t ns: the master response never reached the slave side", $time);
      errors++;
      timed_out = 1'b1;
    end else if (wr && wr_ref_id.size() > 0) begin
      // The master model answers every burst with SLVERR.
      check_val("slv_b_id", 32'(slv_b_id), 32'(wr_ref_id[0]));
      check_val("slv_b", 32'(slv_b), 32'd2);
      check_val("mst_b_ready", 32'(mst_b_ready), 32'd1);
      void'(wr_ref_id.pop_front());
    end else if (!wr && rd_ref_id.size() > 0) begin
      check_val("slv_r_id", 32'(slv_r_id), 32'(rd_ref_id[0]));
      check_val("slv_r.data", slv_r.data, rd_ref_addr[0] + 32'(tb_beat));
      check_val("slv_r.resp", 32'(slv_r.resp), 32'd2);
      check_val("slv_r.last", 32'(slv_r.last), 32'(tb_beat == rd_ref_len[0]));
      check_val("mst_r_ready", 32'(mst_r_ready), 32'd1);
      if (tb_beat == rd_ref_len[0]) begin
        tb_beat = '0;
        void'(rd_ref_id.pop_front());
        void'(rd_ref_addr.pop_front());
        void'(rd_ref_len.pop_front());
      end else begin
        tb_beat = tb_beat + len_t'(1);
      end
    end else begin
      $display("error at %0t ns: a response arrived with no burst in flight", $time);
      errors++;
    end
    @(posedge clk_i);
    #1;
    b_rel = 1'b0;
    r_rel = 1'b0;
  endtask

  task automatic apply_row(input row_t r);
    addr_t a;
    logic acc;
    int n_wait;
    acc = 1'b0;
    n_wait = 0;
    draw_addr(a);
    @(posedge clk_i);
    #1;
    dir_wr = r.wr;
    req_id = r.id;
    req_ax = '{addr: a, len: r.len};
    req_valid = 1'b1;
    hold = (r.hold != 0);
    if (r.stall) begin
      // A refused request sees slave ready low and nothing on the master side.
      repeat (3) begin
        @(negedge clk_i);
        check_val("slv_ready (stalled)", 32'(sel_slv_ready), 32'd0);
        check_val("mst_valid (stalled)", 32'(sel_mst_valid), 32'd0);
      end
      for (int k = 1; k <= int'(r.n_rel); k++) begin
        release_one(r.wr);
        if (k < int'(r.n_rel)) begin
          @(negedge clk_i);
          check_val("slv_ready (no entry freed)", 32'(sel_slv_ready), 32'd0);
        end
      end
    end
    for (int t = 0; t < int'(r.hold); t++) begin
      @(negedge clk_i);
      check_val("mst_valid (held)", 32'(sel_mst_valid), 32'd1);
      check_val("mst_id (held)", 32'(sel_mst_id), 32'(r.oup));
      check_val("mst_addr (held)", sel_mst_addr, a);
      check_val("slv_ready (held)", 32'(sel_slv_ready), 32'd0);
    end
    if (r.hold != 0) begin
      @(posedge clk_i);
      #1;
      hold = 1'b0;
    end
    // Slave ready follows in the same cycle as master ready or a freed entry.
    for (int t = 0; t < 20 && !acc && !timed_out; t++) begin
      @(negedge clk_i);
      acc = sel_slv_ready;
      n_wait++;
    end
    if (!acc) begin
      $display("timeout at %0t ns: request with input ID %0d was never accepted", $time, r.id);
      errors++;
      timed_out = 1'b1;
    end else begin
      check_val("slv_ready wait cycles", 32'(n_wait), 32'd1);
      check_val("mst_valid", 32'(sel_mst_valid), 32'd1);
      check_val("mst_id", 32'(sel_mst_id), 32'(r.oup));
      check_val("mst_addr", sel_mst_addr, a);
      check_val("mst_len", 32'(sel_mst_len), 32'(r.len));
      if (r.wr) begin
        wr_ref_id.push_back(r.id);
      end else begin
        rd_ref_id.push_back(r.id);
        rd_ref_addr.push_back(a);
        rd_ref_len.push_back(r.len);
      end
    end
    @(posedge clk_i);
    #1;
    req_valid = 1'b0;
  endtask

  initial begin
    errors = 0;
    timed_out = 1'b0;
    lfsr = 32'd70395;
    tb_beat = '0;
    arst_n_i = 1'b0;
    dir_wr = 1'b0;
    req_valid = 1'b0;
    req_id = '0;
    req_ax = '0;
    hold = 1'b0;
    b_rel = 1'b0;
    r_rel = 1'b0;
    // Reads and writes count separately; rows 3, 7 and 10 exercise full tables and ID limits.
    rows = '{
      '{1'b0, 6'd5,  8'd0, 4'd0, 4'd0, 1'b0, 2'd0},
      '{1'b1, 6'd5,  8'd0, 4'd0, 4'd0, 1'b0, 2'd0},
      '{1'b0, 6'd5,  8'd1, 4'd0, 4'd0, 1'b0, 2'd0},
      '{1'b0, 6'd5,  8'd0, 4'd0, 4'd1, 1'b1, 2'd0},
      '{1'b0, 6'd9,  8'd0, 4'd0, 4'd0, 1'b0, 2'd1},
      '{1'b0, 6'd12, 8'd0, 4'd0, 4'd0, 1'b0, 2'd2},
      '{1'b0, 6'd33, 8'd0, 4'd0, 4'd0, 1'b0, 2'd3},
      '{1'b0, 6'd40, 8'd0, 4'd0, 4'd3, 1'b1, 2'd0},
      '{1'b1, 6'd7,  8'd0, 4'd3, 4'd0, 1'b0, 2'd1},
      '{1'b1, 6'd7,  8'd0, 4'd0, 4'd0, 1'b0, 2'd1},
      '{1'b1, 6'd7,  8'd0, 4'd0, 4'd2, 1'b1, 2'd1},
      '{1'b1, 6'd20, 8'd0, 4'd2, 4'd0, 1'b0, 2'd0}
    };
    repeat (5) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_val("mst_ar_valid", 32'(mst_ar_valid), 32'd0);
    check_val("mst_aw_valid", 32'(mst_aw_valid), 32'd0);
    check_val("slv_ar_ready", 32'(slv_ar_ready), 32'd0);
    check_val("slv_aw_ready", 32'(slv_aw_ready), 32'd0);
    foreach (rows[i]) begin
      if (!timed_out) begin
        apply_row(rows[i]);
      end
    end
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* id_remap_top.f */
common/id_remap_pkg.sv
id_remap_table/id_remap_table.sv
hdl/id_remap_issue.sv
hdl/id_remap_top.sv
tb/mst_responder.sv
tb/id_remap_tb.sv

/* Makefile */
# Verilator build and run for the ID remapper testbench.
TOP = id_remap_tb

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f id_remap_top.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TESTBENCH PASSED$$"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f id_remap_top.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
